// ==== source/rename_cfg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register space sizes. PHYS_REGS must exceed ARCH_REGS and
// ROB_DEPTH_MAX bounds the ROB index type
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rename_cfg_pkg;

    // Architectural register count, RISC-V integer file
    localparam int ARCH_REGS = 32;

    // Physical register count
    localparam int PHYS_REGS = 48;

    // Largest ROB the index type can address
    localparam int ROB_DEPTH_MAX = 16;

    // Registers left on the free list after reset
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

endpackage

`default_nettype wire

// ==== source/rename_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Index types, sized from the register spaces in rename_cfg_pkg
//////////////////////////////////////////////////////////////////////

`default_nettype none

package rename_types_pkg;

    // Architectural register number
    typedef logic [$clog2(rename_cfg_pkg::ARCH_REGS)-1:0] arch_reg_t;

    // Physical register number
    typedef logic [$clog2(rename_cfg_pkg::PHYS_REGS)-1:0] phys_reg_t;

    // ROB slot number, wide enough for the largest ROB
    // Smaller ROBs use only the low bits
    typedef logic [$clog2(rename_cfg_pkg::ROB_DEPTH_MAX)-1:0] rob_idx_t;

endpackage

`default_nettype wire

// ==== source/rename_if.sv ====
//////////////////////////////////////////////////////////////////////
// Rename-to-ROB and ROB-to-retire links. ROB_DEPTH must match the
// rob instance on the other end
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

// Allocation of the tail entry, one per cycle
interface rob_alloc_if #(parameter int ROB_DEPTH = 8);
    import rename_types_pkg::*;

    logic      alloc;
    logic      rd_wen;
    arch_reg_t rd_arch;
    phys_reg_t new_prf;
    phys_reg_t old_prf;
    logic      has_space;
    rob_idx_t  tail_idx;
    // Entries held, 0 up to ROB_DEPTH
    logic [$clog2(ROB_DEPTH+1)-1:0] count;

    modport renamer (output alloc, rd_wen, rd_arch, new_prf, old_prf,
                     input has_space, tail_idx);
    modport rob (input alloc, rd_wen, rd_arch, new_prf, old_prf,
                 output has_space, tail_idx, count);
endinterface

// Oldest entry and its release strobe
interface rob_head_if;
    import rename_types_pkg::*;

    logic      head_valid;
    logic      head_done;
    logic      rd_wen;
    arch_reg_t rd_arch;
    phys_reg_t new_prf;
    phys_reg_t old_prf;
    logic      pop;

    modport rob (output head_valid, head_done, rd_wen, rd_arch, new_prf, old_prf,
                 input pop);
    modport retirer (input head_valid, head_done, rd_wen, rd_arch, new_prf, old_prf,
                     output pop);
endinterface

`default_nettype wire

// ==== source/map_table.sv ====
//////////////////////////////////////////////////////////////////////
// Speculative rename map, reads are combinational and see the old
// value in the cycle of a write
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module map_table (
    input  logic                        clock,
    input  logic                        reset,
    input  rename_types_pkg::arch_reg_t rs1_arch_i,
    input  rename_types_pkg::arch_reg_t rs2_arch_i,
    input  rename_types_pkg::arch_reg_t rd_arch_i,
    output rename_types_pkg::phys_reg_t rs1_prf_o,
    output rename_types_pkg::phys_reg_t rs2_prf_o,
    output rename_types_pkg::phys_reg_t rd_prf_o,
    input  logic                        write_i,
    input  rename_types_pkg::phys_reg_t write_prf_i
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // One physical number per architectural register
    phys_reg_t map_q [ARCH_REGS];

    // Source and old destination lookups
    assign rs1_prf_o = map_q[rs1_arch_i];
    assign rs2_prf_o = map_q[rs2_arch_i];
    assign rd_prf_o  = map_q[rd_arch_i];

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, x<n> lives in p<n>
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else if (write_i) begin
            // Caller keeps x0 out of here
            map_q[rd_arch_i] <= write_prf_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
//////////////////////////////////////////////////////////////////////
// Free physical registers in release order. No bypass, a register
// pushed at an edge is poppable from the next cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module free_list (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        pop_i,
    output rename_types_pkg::phys_reg_t head_prf_o,
    output logic                        empty_o,
    input  logic                        push_i,
    input  rename_types_pkg::phys_reg_t push_prf_i
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int PTR_W = $clog2(PHYS_REGS);
    localparam int CNT_W = $clog2(PHYS_REGS + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(PHYS_REGS - 1);

    phys_reg_t        slots_q [PHYS_REGS];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign head_prf_o = slots_q[rd_ptr_q];
    assign empty_o    = (count_q == '0);

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= PTR_W'(FREE_REGS);
            count_q  <= CNT_W'(FREE_REGS);
        end else begin
            // Depth is not a power of two, wrap by hand
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            unique case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Slot storage, preloaded with the upper registers
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                slots_q[i] <= phys_reg_t'((i < FREE_REGS) ? ARCH_REGS + i : 0);
            end
        end else if (push_i) begin
            slots_q[wr_ptr_q] <= push_prf_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_stage.sv ====
//////////////////////////////////////////////////////////////////////
// One dispatch per cycle. Ready and renamed outputs are combinational
// and x0 or rd_wen low never takes a register
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rename_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        disp_valid_i,
    input  logic                        disp_rd_wen_i,
    input  rename_types_pkg::arch_reg_t disp_rd_arch_i,
    input  rename_types_pkg::arch_reg_t disp_rs1_arch_i,
    input  rename_types_pkg::arch_reg_t disp_rs2_arch_i,
    output logic                        disp_ready_o,
    output rename_types_pkg::phys_reg_t disp_new_prf_o,
    output rename_types_pkg::phys_reg_t disp_old_prf_o,
    output rename_types_pkg::phys_reg_t disp_rs1_prf_o,
    output rename_types_pkg::phys_reg_t disp_rs2_prf_o,
    input  logic                        release_valid_i,
    input  rename_types_pkg::phys_reg_t release_prf_i,
    rob_alloc_if.renamer                alloc
);
    import rename_types_pkg::*;

    logic      rd_write;
    logic      accept;
    logic      fl_empty;
    phys_reg_t fl_head;
    phys_reg_t rd_prf;

    // Real destination write, x0 excluded
    assign rd_write = disp_rd_wen_i && (disp_rd_arch_i != '0);

    // Needs a ROB slot, and a free register only when writing
    assign disp_ready_o = alloc.has_space && !(rd_write && fl_empty);
    assign accept       = disp_valid_i && disp_ready_o;

    // Non-writers report the current mapping twice
    assign disp_new_prf_o = rd_write ? fl_head : rd_prf;
    assign disp_old_prf_o = rd_prf;

    map_table i_map_table (
        .clock       (clock),
        .reset       (reset),
        .rs1_arch_i  (disp_rs1_arch_i),
        .rs2_arch_i  (disp_rs2_arch_i),
        .rd_arch_i   (disp_rd_arch_i),
        .rs1_prf_o   (disp_rs1_prf_o),
        .rs2_prf_o   (disp_rs2_prf_o),
        .rd_prf_o    (rd_prf),
        .write_i     (accept && rd_write),
        .write_prf_i (fl_head)
    );

    free_list i_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_i      (accept && rd_write),
        .head_prf_o (fl_head),
        .empty_o    (fl_empty),
        .push_i     (release_valid_i),
        .push_prf_i (release_prf_i)
    );

    // ROB entry carries the effective write flag
    assign alloc.alloc   = accept;
    assign alloc.rd_wen  = rd_write;
    assign alloc.rd_arch = disp_rd_arch_i;
    assign alloc.new_prf = disp_new_prf_o;
    assign alloc.old_prf = rd_prf;

endmodule

`default_nettype wire

// ==== source/rob.sv ====
//////////////////////////////////////////////////////////////////////
// ROB_DEPTH must be a power of two, 2 to 16. Writeback is only legal
// for held entries that are not yet done
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    rob_alloc_if.rob                   alloc,
    input  logic                       wb_valid_i,
    input  rename_types_pkg::rob_idx_t wb_rob_idx_i,
    rob_head_if.rob                    head
);
    import rename_types_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Entry payload
    logic      rd_wen_q  [ROB_DEPTH];
    arch_reg_t rd_arch_q [ROB_DEPTH];
    phys_reg_t new_prf_q [ROB_DEPTH];
    phys_reg_t old_prf_q [ROB_DEPTH];
    // Completion flags
    logic [ROB_DEPTH-1:0] done_q;

    // Pointers wrap on their own width
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    //////////////////////////////////////////////////////////////////////
    // Allocation side
    assign alloc.has_space = (count_q != CNT_W'(ROB_DEPTH));
    assign alloc.tail_idx  = rob_idx_t'(tail_q);
    assign alloc.count     = count_q;

    //////////////////////////////////////////////////////////////////////
    // Oldest entry
    assign head.head_valid = (count_q != '0);
    assign head.head_done  = done_q[head_q];
    assign head.rd_wen     = rd_wen_q[head_q];
    assign head.rd_arch    = rd_arch_q[head_q];
    assign head.new_prf    = new_prf_q[head_q];
    assign head.old_prf    = old_prf_q[head_q];

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc.alloc) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            // Never the tail slot, that one is not held
            if (wb_valid_i) begin
                done_q[wb_rob_idx_i[IDX_W-1:0]] <= 1'b1;
            end
            if (head.pop) begin
                head_q <= head_q + 1'b1;
            end
            unique case ({alloc.alloc, head.pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload written at the tail
    always_ff @(posedge clock) begin
        if (alloc.alloc) begin
            rd_wen_q[tail_q]  <= alloc.rd_wen;
            rd_arch_q[tail_q] <= alloc.rd_arch;
            new_prf_q[tail_q] <= alloc.new_prf;
            old_prf_q[tail_q] <= alloc.old_prf;
        end
    end

endmodule

`default_nettype wire

// ==== source/retire_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Commits at most one entry per cycle, the commit record shows up
// one cycle after the pop
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module retire_unit (
    input  logic                        clock,
    input  logic                        reset,
    rob_head_if.retirer                 head,
    output logic                        release_valid_o,
    output rename_types_pkg::phys_reg_t release_prf_o,
    output logic                        commit_valid_o,
    output logic                        commit_rd_wen_o,
    output rename_types_pkg::arch_reg_t commit_rd_arch_o,
    output rename_types_pkg::phys_reg_t commit_new_prf_o,
    output rename_types_pkg::phys_reg_t commit_old_prf_o
);

    logic pop;

    // Head leaves as soon as it is complete
    assign pop      = head.head_valid && head.head_done;
    assign head.pop = pop;

    // Old mapping goes back to the free list at the same edge
    assign release_valid_o = pop && head.rd_wen;
    assign release_prf_o   = head.old_prf;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= pop;
        end
    end

    // Commit record, meaningful only with commit_valid_o
    always_ff @(posedge clock) begin
        if (pop) begin
            commit_rd_wen_o  <= head.rd_wen;
            commit_rd_arch_o <= head.rd_arch;
            commit_new_prf_o <= head.new_prf;
            commit_old_prf_o <= head.old_prf;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_core.sv ====
//////////////////////////////////////////////////////////////////////
// Rename and retire core, one instruction per cycle each way.
// ROB_DEPTH is a power of two from 2 to 16
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rename_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    // Dispatch
    input  logic                        disp_valid_i,
    input  logic                        disp_rd_wen_i,
    input  rename_types_pkg::arch_reg_t disp_rd_arch_i,
    input  rename_types_pkg::arch_reg_t disp_rs1_arch_i,
    input  rename_types_pkg::arch_reg_t disp_rs2_arch_i,
    output logic                        disp_ready_o,
    output rename_types_pkg::rob_idx_t  disp_rob_idx_o,
    output rename_types_pkg::phys_reg_t disp_new_prf_o,
    output rename_types_pkg::phys_reg_t disp_old_prf_o,
    output rename_types_pkg::phys_reg_t disp_rs1_prf_o,
    output rename_types_pkg::phys_reg_t disp_rs2_prf_o,
    // Completion
    input  logic                        wb_valid_i,
    input  rename_types_pkg::rob_idx_t  wb_rob_idx_i,
    // Commit
    output logic                        commit_valid_o,
    output logic                        commit_rd_wen_o,
    output rename_types_pkg::arch_reg_t commit_rd_arch_o,
    output rename_types_pkg::phys_reg_t commit_new_prf_o,
    output rename_types_pkg::phys_reg_t commit_old_prf_o
);
    import rename_types_pkg::*;

    // Retire to free list
    logic      release_valid;
    phys_reg_t release_prf;

    rob_alloc_if #(.ROB_DEPTH(ROB_DEPTH)) i_alloc_if ();
    rob_head_if i_head_if ();

    // Slot the current dispatch would take
    assign disp_rob_idx_o = i_alloc_if.tail_idx;

    rename_stage i_rename_stage (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_rd_wen_i   (disp_rd_wen_i),
        .disp_rd_arch_i  (disp_rd_arch_i),
        .disp_rs1_arch_i (disp_rs1_arch_i),
        .disp_rs2_arch_i (disp_rs2_arch_i),
        .disp_ready_o    (disp_ready_o),
        .disp_new_prf_o  (disp_new_prf_o),
        .disp_old_prf_o  (disp_old_prf_o),
        .disp_rs1_prf_o  (disp_rs1_prf_o),
        .disp_rs2_prf_o  (disp_rs2_prf_o),
        .release_valid_i (release_valid),
        .release_prf_i   (release_prf),
        .alloc           (i_alloc_if.renamer)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
        .clock        (clock),
        .reset        (reset),
        .alloc        (i_alloc_if.rob),
        .wb_valid_i   (wb_valid_i),
        .wb_rob_idx_i (wb_rob_idx_i),
        .head         (i_head_if.rob)
    );

    retire_unit i_retire_unit (
        .clock            (clock),
        .reset            (reset),
        .head             (i_head_if.retirer),
        .release_valid_o  (release_valid),
        .release_prf_o    (release_prf),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o)
    );

endmodule

`default_nettype wire

// ==== bench/rename_core_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Bound into rename_core. ROB occupancy and the allocation strobe
// come from the allocation interface inside the core
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rename_core_properties #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             alloc_i,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]   rob_count_i,
    input  logic                             commit_valid_i,
    input  logic                             commit_rd_wen_i,
    input  rename_types_pkg::phys_reg_t      commit_new_prf_i,
    input  rename_types_pkg::phys_reg_t      commit_old_prf_i
);

    // Failures seen so far
    int fail_count = 0;

    // Empty ROB after reset, nothing can retire for three samples
    commit_quiet_after_reset: assert property (@(posedge clock)
        reset |=> !commit_valid_i [*3])
    else begin
        $error("commit seen right after reset");
        fail_count++;
    end

    // Full ROB takes no new entry
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        (rob_count_i == ($bits(rob_count_i))'(ROB_DEPTH)) |-> !alloc_i)
    else begin
        $error("allocation into a full ROB");
        fail_count++;
    end

    // A real write always moved rd to a fresh register
    commit_new_differs_old: assert property (@(posedge clock) disable iff (reset)
        (commit_valid_i && commit_rd_wen_i) |-> (commit_new_prf_i != commit_old_prf_i))
    else begin
        $error("committed write has new register equal to old");
        fail_count++;
    end

endmodule

bind rename_core rename_core_properties #(.ROB_DEPTH(ROB_DEPTH)) i_props (
    .clock            (clock),
    .reset            (reset),
    .alloc_i          (i_alloc_if.alloc),
    .rob_count_i      (i_alloc_if.count),
    .commit_valid_i   (commit_valid_o),
    .commit_rd_wen_i  (commit_rd_wen_o),
    .commit_new_prf_i (commit_new_prf_o),
    .commit_old_prf_i (commit_old_prf_o)
);

`default_nettype wire

// ==== bench/rename_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Table-driven test at ROB_DEPTH 8 against a reference model.
// Stops at the first mismatch or at a stuck wait
//////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rename_core_tb;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int ROB_DEPTH  = 8;
    localparam int WAIT_LIMIT = 50;
    localparam int ROWS       = 20;
    localparam int SEQ_MAX    = 64;
    localparam logic [1:0] OP_DISP  = 2'd0;
    localparam logic [1:0] OP_COMP  = 2'd1;
    localparam logic [1:0] OP_DRAIN = 2'd2;

    // One table row, count repeats the op with rd or pos stepping up
    typedef struct packed {
        logic [1:0] op;
        logic       rd_wen;
        arch_reg_t  rd;
        logic [5:0] pos;
        logic [3:0] count;
        logic       ready;
    } row_t;

    logic      clock;
    logic      reset;
    logic      disp_valid_i;
    logic      disp_rd_wen_i;
    arch_reg_t disp_rd_arch_i;
    arch_reg_t disp_rs1_arch_i;
    arch_reg_t disp_rs2_arch_i;
    logic      disp_ready_o;
    rob_idx_t  disp_rob_idx_o;
    phys_reg_t disp_new_prf_o;
    phys_reg_t disp_old_prf_o;
    phys_reg_t disp_rs1_prf_o;
    phys_reg_t disp_rs2_prf_o;
    logic      wb_valid_i;
    rob_idx_t  wb_rob_idx_i;
    logic      commit_valid_o;
    logic      commit_rd_wen_o;
    arch_reg_t commit_rd_arch_o;
    phys_reg_t commit_new_prf_o;
    phys_reg_t commit_old_prf_o;

    ////////////////////////////////////////////////////////////////////////
    // Reference model state
    phys_reg_t   ref_map [ARCH_REGS];
    phys_reg_t   free_q [$];
    // Per dispatch sequence number
    logic        e_wen [SEQ_MAX];
    arch_reg_t   e_rd [SEQ_MAX];
    phys_reg_t   e_new [SEQ_MAX];
    phys_reg_t   e_old [SEQ_MAX];
    logic        e_done [SEQ_MAX];
    int          e_done_cyc [SEQ_MAX];
    int          disp_cnt;
    int          commit_ptr;
    int          row_no;
    int          cycle_no = 0;
    logic [15:0] lfsr_q;
    row_t        stim [ROWS];

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) i_rename_core (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid_i),
        .disp_rd_wen_i    (disp_rd_wen_i),
        .disp_rd_arch_i   (disp_rd_arch_i),
        .disp_rs1_arch_i  (disp_rs1_arch_i),
        .disp_rs2_arch_i  (disp_rs2_arch_i),
        .disp_ready_o     (disp_ready_o),
        .disp_rob_idx_o   (disp_rob_idx_o),
        .disp_new_prf_o   (disp_new_prf_o),
        .disp_old_prf_o   (disp_old_prf_o),
        .disp_rs1_prf_o   (disp_rs1_prf_o),
        .disp_rs2_prf_o   (disp_rs2_prf_o),
        .wb_valid_i       (wb_valid_i),
        .wb_rob_idx_i     (wb_rob_idx_i),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Cycle stamp, read only at the falling edge
    always @(posedge clock) cycle_no <= cycle_no + 1;

    // 16-bit Fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit taken
    task automatic take_arch(output arch_reg_t r);
        for (int i = 0; i < $bits(arch_reg_t); i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r[i]   = lfsr_q[0];
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_phys(input string what, input phys_reg_t exp, input phys_reg_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: expected %0d, actual %0d",
                                row_no, what, exp, act));
        end
    endtask

    task automatic check_arch(input string what, input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: expected %0d, actual %0d",
                                row_no, what, exp, act));
        end
    endtask

    task automatic check_idx(input string what, input rob_idx_t exp, input rob_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: expected %0d, actual %0d",
                                row_no, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: expected %0b, actual %0b",
                                row_no, what, exp, act));
        end
    endtask

    // Free slot in the ROB, and a free register if it writes
    function automatic logic model_ready(input logic wr);
        return ((disp_cnt - commit_ptr) < ROB_DEPTH) && !(wr && free_q.size() == 0);
    endfunction

    // Head retires two edges after its completing edge at the earliest
    task automatic observe_commit();
        int   p;
        logic due;
        p   = commit_ptr;
        due = (p < disp_cnt) && e_done[p] && (cycle_no >= e_done_cyc[p] + 2);
        check_bit("commit valid", due, commit_valid_o);
        if (due) begin
            check_bit("commit rd_wen", e_wen[p], commit_rd_wen_o);
            check_arch("commit rd", e_rd[p], commit_rd_arch_o);
            check_phys("commit new", e_new[p], commit_new_prf_o);
            check_phys("commit old", e_old[p], commit_old_prf_o);
            // Old mapping usable again from this cycle
            if (e_wen[p]) begin
                free_q.push_back(e_old[p]);
            end
            commit_ptr++;
        end
    endtask

    // Holds the request until accepted
    task automatic dispatch_one(input row_t r, input arch_reg_t rd);
        arch_reg_t rs1;
        arch_reg_t rs2;
        phys_reg_t exp_new;
        logic      wr;
        logic      accepted;
        int        waited;
        take_arch(rs1);
        take_arch(rs2);
        wr              = r.rd_wen && (rd != '0);
        accepted        = 1'b0;
        waited          = 0;
        disp_valid_i    = 1'b1;
        disp_rd_wen_i   = r.rd_wen;
        disp_rd_arch_i  = rd;
        disp_rs1_arch_i = rs1;
        disp_rs2_arch_i = rs2;
        while (!accepted) begin
            @(negedge clock);
            observe_commit();
            check_bit("ready", model_ready(wr), disp_ready_o);
            if (waited == 0) begin
                check_bit("table ready", r.ready, disp_ready_o);
            end
            if (disp_ready_o) begin
                exp_new = wr ? free_q[0] : ref_map[rd];
                check_idx("rob index", rob_idx_t'(disp_cnt % ROB_DEPTH), disp_rob_idx_o);
                check_phys("rs1", ref_map[rs1], disp_rs1_prf_o);
                check_phys("rs2", ref_map[rs2], disp_rs2_prf_o);
                check_phys("old", ref_map[rd], disp_old_prf_o);
                check_phys("new", exp_new, disp_new_prf_o);
                e_wen[disp_cnt]  = wr;
                e_rd[disp_cnt]   = rd;
                e_new[disp_cnt]  = exp_new;
                e_old[disp_cnt]  = ref_map[rd];
                e_done[disp_cnt] = 1'b0;
                if (wr) begin
                    ref_map[rd] = exp_new;
                    void'(free_q.pop_front());
                end
                disp_cnt++;
                accepted = 1'b1;
            end else if (waited == WAIT_LIMIT) begin
                abort_run("dispatch stayed blocked, ready never rose");
            end
            waited++;
            @(posedge clock);
            #2;
        end
        disp_valid_i = 1'b0;
    endtask

    // Writeback by dispatch position
    task automatic complete_one(input int pos);
        wb_valid_i   = 1'b1;
        wb_rob_idx_i = rob_idx_t'(pos % ROB_DEPTH);
        @(negedge clock);
        observe_commit();
        e_done[pos]     = 1'b1;
        e_done_cyc[pos] = cycle_no;
        @(posedge clock);
        #2;
        wb_valid_i = 1'b0;
    endtask

    task automatic drain_rob();
        int waited;
        waited = 0;
        while (commit_ptr != disp_cnt) begin
            @(negedge clock);
            observe_commit();
            if (commit_ptr != disp_cnt && waited == WAIT_LIMIT) begin
                abort_run("ROB did not drain, commits stopped");
            end
            waited++;
            @(posedge clock);
            #2;
        end
    endtask

    // Assertion failures end the run as well
    always @(negedge clock) begin
        if (i_rename_core.i_props.fail_count != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    initial begin
        lfsr_q          = 16'd21298;
        reset           = 1'b1;
        disp_valid_i    = 1'b0;
        disp_rd_wen_i   = 1'b0;
        disp_rd_arch_i  = '0;
        disp_rs1_arch_i = '0;
        disp_rs2_arch_i = '0;
        wb_valid_i      = 1'b0;
        wb_rob_idx_i    = '0;
        disp_cnt        = 0;
        commit_ptr      = 0;
        row_no          = 0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_map[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < FREE_REGS; i++) begin
            free_q.push_back(phys_reg_t'(ARCH_REGS + i));
        end

        // op, rd_wen, rd, pos, count, ready
        // First renames from identity, then x0 and rd_wen low
        stim[0]  = '{OP_DISP, 1'b1, 5'd1, 6'd0, 4'd4, 1'b1};
        stim[1]  = '{OP_DISP, 1'b0, 5'd5, 6'd0, 4'd1, 1'b1};
        stim[2]  = '{OP_DISP, 1'b1, 5'd0, 6'd0, 4'd1, 1'b1};
        stim[3]  = '{OP_DISP, 1'b1, 5'd1, 6'd0, 4'd1, 1'b1};
        // Out of order completion, in order commit
        stim[4]  = '{OP_COMP, 1'b0, 5'd0, 6'd3, 4'd1, 1'b0};
        stim[5]  = '{OP_COMP, 1'b0, 5'd0, 6'd1, 4'd1, 1'b0};
        stim[6]  = '{OP_COMP, 1'b0, 5'd0, 6'd0, 4'd1, 1'b0};
        stim[7]  = '{OP_COMP, 1'b0, 5'd0, 6'd2, 4'd1, 1'b0};
        stim[8]  = '{OP_COMP, 1'b0, 5'd0, 6'd6, 4'd1, 1'b0};
        stim[9]  = '{OP_COMP, 1'b0, 5'd0, 6'd5, 4'd1, 1'b0};
        stim[10] = '{OP_COMP, 1'b0, 5'd0, 6'd4, 4'd1, 1'b0};
        stim[11] = '{OP_DRAIN, 1'b0, 5'd0, 6'd0, 4'd0, 1'b0};
        // Fill the ROB, then a request blocked until the head retires
        stim[12] = '{OP_DISP, 1'b1, 5'd6, 6'd0, 4'd8, 1'b1};
        stim[13] = '{OP_COMP, 1'b0, 5'd0, 6'd7, 4'd1, 1'b0};
        stim[14] = '{OP_DISP, 1'b1, 5'd14, 6'd0, 4'd1, 1'b0};
        stim[15] = '{OP_COMP, 1'b0, 5'd0, 6'd8, 4'd8, 1'b0};
        stim[16] = '{OP_DRAIN, 1'b0, 5'd0, 6'd0, 4'd0, 1'b0};
        // Past the 16 reset registers, released ones come back in order
        // Free list never drains with 8 ROB slots, in-flight writers bound it
        stim[17] = '{OP_DISP, 1'b1, 5'd20, 6'd0, 4'd6, 1'b1};
        stim[18] = '{OP_COMP, 1'b0, 5'd0, 6'd16, 4'd6, 1'b0};
        stim[19] = '{OP_DRAIN, 1'b0, 5'd0, 6'd0, 4'd0, 1'b0};

        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int n = 0; n < ROWS; n++) begin
            row_no = n;
            case (stim[n].op)
                OP_DISP: begin
                    for (int j = 0; j < int'(stim[n].count); j++) begin
                        dispatch_one(stim[n], arch_reg_t'(int'(stim[n].rd) + j));
                    end
                end
                OP_COMP: begin
                    for (int j = 0; j < int'(stim[n].count); j++) begin
                        complete_one(int'(stim[n].pos) + j);
                    end
                end
                default: drain_rob();
            endcase
        end

        if (i_rename_core.i_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("a bound assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/rename_cfg_pkg.sv
source/rename_types_pkg.sv
source/rename_if.sv
source/map_table.sv
source/free_list.sv
source/rename_stage.sv
source/rob.sv
source/retire_unit.sv
source/rename_core.sv
bench/rename_core_properties.sv
bench/rename_core_tb.sv

// ==== Makefile ====
# Verilator flow for the rename core

VERILATOR ?= verilator
TOP       ?= rename_core_tb
RTL_TOP   ?= rename_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
